// ==== branch_predictor.f ====
+incdir+rtl
rtl/lc3b_isa_pkg.sv
rtl/bp_pkg.sv
rtl/bp_update_if.sv
rtl/history_indexer.sv
rtl/counter_bank.sv
rtl/prediction_gen.sv
rtl/branch_predictor.sv
testbench/tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --timescale 1ns/1ps \
        -f branch_predictor.f --top-module tb_branch_predictor; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_branch_predictor)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q -F -x '** PASS **'; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

// ==== testbench/tb_branch_predictor.sv ====
`timescale 1ns/1ps

module tb_branch_predictor import lc3b_isa_pkg::*;
();

localparam int half_period = 20;
localparam int sample_delay = 18;       // just before the rising edge
localparam int reset_cycles = 4;
localparam int random_cycles = 400;
localparam int max_wait = 64;
localparam int watchdog_ns = 100000;

typedef struct packed
{
    logic [3:0] test;
    lc3b_word   fetch_pc;
    lc3b_word   fetch_instr;
    logic       resolve_valid;
    lc3b_word   resolve_pc;
    logic       resolve_taken;
    logic       exp_taken;
    lc3b_word   exp_pc;
} row_t;

logic     clk;
logic     reset;
lc3b_word fetch_pc;
lc3b_word fetch_instr;
logic     resolve_valid;
lc3b_word resolve_pc;
logic     resolve_taken;
logic     predict_taken;
lc3b_word predicted_pc;

row_t       rows [$];
logic [4:0] ref_hist [32];      // reference local histories
int         ref_cnt [32];       // reference counters from 0 (strongly_nt) to 3 (strongly_t)
int         errors;
int         checks;
int         tests_run;
int         test_errors;
int         test_rows;

branch_predictor UUT
(
    .clk(clk),
    .reset(reset),
    .fetch_pc(fetch_pc),
    .fetch_instr(fetch_instr),
    .resolve_valid(resolve_valid),
    .resolve_pc(resolve_pc),
    .resolve_taken(resolve_taken),
    .predict_taken(predict_taken),
    .predicted_pc(predicted_pc)
);

initial
begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
end

initial
begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("** FAIL **");
    $finish;
end

task automatic wait_negedges(input int n);
    int waited;
    waited = 0;
    while (waited < n && waited < max_wait)
    begin
        @(negedge clk);
        waited++;
    end
    if (waited < n)
    begin
        $display("a wait of %0d cycles is longer than the limit of %0d", n, max_wait);
        errors++;
    end
endtask

task automatic apply_reset();
    wait_negedges(1);
    reset = 1'b1;
    resolve_valid = 1'b0;
    wait_negedges(reset_cycles);
    reset = 1'b0;
endtask

task automatic check_outputs(input logic exp_taken, input lc3b_word exp_pc, input string where);
    checks++;
    assert (predict_taken === exp_taken)
    else
    begin
        $display("error: %s predict_taken got %h expected %h", where, predict_taken, exp_taken);
        errors++;
        test_errors++;
    end
    assert (predicted_pc === exp_pc)
    else
    begin
        $display("error: %s predicted_pc got %h expected %h", where, predicted_pc, exp_pc);
        errors++;
        test_errors++;
    end
endtask

task automatic add_row(input logic [3:0] test, input lc3b_word pc, input lc3b_word instr,
                       input logic rv, input lc3b_word rpc, input logic rt,
                       input logic exp_taken, input lc3b_word exp_pc);
    rows.push_back({test, pc, instr, rv, rpc, rt, exp_taken, exp_pc});
endtask

task automatic apply_row(input row_t r, input int row_num);
    wait_negedges(1);
    fetch_pc = r.fetch_pc;
    fetch_instr = r.fetch_instr;
    resolve_valid = r.resolve_valid;
    resolve_pc = r.resolve_pc;
    resolve_taken = r.resolve_taken;
    #(sample_delay);
    check_outputs(r.exp_taken, r.exp_pc, $sformatf("test %0d row %0d", r.test, row_num));
endtask

function automatic string test_name(input logic [3:0] num);
    string name;
    case (num)
        4'd1: name = "after reset";
        4'd2: name = "training";
        4'd3: name = "saturation and hysteresis";
        4'd4: name = "non-branches";
        4'd5: name = "same-cycle update";
        default: name = "random";
    endcase
    return name;
endfunction

task automatic build_table();
    // test, fetch pc, instr, resolve valid, resolve pc, taken, exp taken, exp pc
    add_row(1, 16'h3000, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h300C);
    add_row(1, 16'h3010, 16'h0FFE, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h300E);
    add_row(1, 16'h1234, 16'h0B00, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h1036);
    add_row(1, 16'h0000, 16'h01FF, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h0000);
    add_row(1, 16'hFFFE, 16'h0EFF, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h01FE);
    // slot 4 trains, then its lookup moves to index 5
    add_row(2, 16'h3004, 16'h0E05, 1'b1, 16'h3004, 1'b1, 1'b0, 16'h3010);
    add_row(2, 16'h3004, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h3010);
    add_row(2, 16'h3004, 16'h0E05, 1'b1, 16'h3025, 1'b1, 1'b0, 16'h3010);
    add_row(2, 16'h3004, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h3010);
    add_row(2, 16'h3025, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h3031);
    // slot 1 saturates its history, then keeps hitting index 30 past strongly_t
    repeat (6)
        add_row(3, 16'h401E, 16'h0E05, 1'b1, 16'h4001, 1'b1, 1'b0, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b1, 16'h4001, 1'b1, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b1, 16'h4001, 1'b1, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b1, 16'h401E, 1'b0, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b1, 16'h401E, 1'b0, 1'b1, 16'h402A);
    add_row(3, 16'h401E, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h402A);
    add_row(4, 16'h5008, 16'h0E05, 1'b1, 16'h5008, 1'b1, 1'b0, 16'h5014);
    add_row(4, 16'h5008, 16'h0E05, 1'b1, 16'h5009, 1'b1, 1'b0, 16'h5014);
    add_row(4, 16'h5008, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h5014);
    add_row(4, 16'h5008, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h500A);
    add_row(4, 16'h5008, 16'h1E05, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h5014);
    add_row(4, 16'h5008, 16'hC1C0, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h4F8A);
    add_row(4, 16'h5008, 16'h4FFF, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h5008);
    add_row(4, 16'h5008, 16'h0405, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h5014);
    // index 16 trained through slot 17, then untrained by slot 16 itself
    add_row(5, 16'h6010, 16'h0E05, 1'b1, 16'h6011, 1'b1, 1'b0, 16'h601C);
    add_row(5, 16'h6010, 16'h0E05, 1'b1, 16'h6011, 1'b1, 1'b0, 16'h601C);
    add_row(5, 16'h6010, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b1, 16'h601C);
    add_row(5, 16'h6010, 16'h0E05, 1'b1, 16'h6010, 1'b0, 1'b1, 16'h601C);
    add_row(5, 16'h6010, 16'h0E05, 1'b0, 16'h0000, 1'b0, 1'b0, 16'h601C);
endtask

task automatic model_reset();
    for (int i = 0; i < 32; i++)
    begin
        ref_hist[i] = 5'b00000;
        ref_cnt[i] = 1;     // weakly_nt
    end
endtask

function automatic logic model_predict(input lc3b_word pc, input lc3b_word instr);
    logic [4:0] slot;
    logic       is_br;
    slot = pc[4:0];
    is_br = (instr[15:12] == 4'b0000) && (instr != 16'h0000);
    return is_br && (ref_cnt[slot ^ ref_hist[slot]] >= 2);
endfunction

function automatic lc3b_word model_target(input lc3b_word pc, input lc3b_word instr);
    int offset;
    offset = int'(instr[8:0]);
    if (instr[8])
    begin
        offset = offset - 512;      // negative offset9
    end
    return 16'(int'(pc) + 2 + 2 * offset);
endfunction

task automatic model_update(input lc3b_word pc, input logic taken);
    logic [4:0] slot;
    logic [4:0] idx;
    slot = pc[4:0];
    idx = slot ^ ref_hist[slot];    // history before this update
    if (taken && ref_cnt[idx] < 3)
    begin
        ref_cnt[idx]++;
    end
    else if (!taken && ref_cnt[idx] > 0)
    begin
        ref_cnt[idx]--;
    end
    ref_hist[slot] = {ref_hist[slot][3:0], taken};
endtask

task automatic run_random();
    logic [31:0] draw;
    logic        exp_taken;
    lc3b_word    exp_pc;
    int          taken_count;
    taken_count = 0;
    test_errors = 0;
    apply_reset();
    model_reset();
    for (int n = 0; n < random_cycles; n++)
    begin
        wait_negedges(1);
        draw = $urandom();
        fetch_pc = draw[15:0];
        draw = $urandom();
        fetch_instr = draw[15:0];
        if (draw[31:29] == 3'd0)
        begin
            fetch_instr = 16'h0000;     // NOP now and then
        end
        else if (draw[31:29] != 3'd1)
        begin
            fetch_instr[15:12] = 4'b0000;   // mostly BR
        end
        draw = $urandom();
        resolve_valid = |draw[1:0];
        resolve_taken = |draw[3:2];
        resolve_pc = (draw[5:4] == 2'b00) ? fetch_pc : draw[31:16];
        exp_taken = model_predict(fetch_pc, fetch_instr);
        exp_pc = model_target(fetch_pc, fetch_instr);
        #(sample_delay);
        check_outputs(exp_taken, exp_pc, $sformatf("random cycle %0d", n));
        if (exp_taken)
        begin
            taken_count++;
        end
        if (resolve_valid)
        begin
            model_update(resolve_pc, resolve_taken);
        end
    end
    tests_run++;
    $display("test 6 %s: %0d cycles, %0d predicted taken, %0d errors",
             test_name(4'd6), random_cycles, taken_count, test_errors);
endtask

initial
begin
    reset = 1'b1;
    fetch_pc = 16'h0000;
    fetch_instr = 16'h0000;
    resolve_valid = 1'b0;
    resolve_pc = 16'h0000;
    resolve_taken = 1'b0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    void'($urandom(32'he9c8d982));
    build_table();
    wait_negedges(reset_cycles);
    reset = 1'b0;

    for (int i = 0; i < rows.size(); i++)
    begin
        if (i == 0 || rows[i].test != rows[i-1].test)
        begin
            apply_reset();      // every directed test starts from reset
            test_errors = 0;
            test_rows = 0;
        end
        apply_row(rows[i], test_rows);
        test_rows++;
        if (i == rows.size() - 1 || rows[i+1].test != rows[i].test)
        begin
            tests_run++;
            $display("test %0d %s: %0d rows, %0d errors",
                     rows[i].test, test_name(rows[i].test), test_rows, test_errors);
        end
    end

    run_random();

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
    begin
        $display("** PASS **");
    end
    else
    begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule : tb_branch_predictor

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_defines.svh"

module branch_predictor import lc3b_isa_pkg::*, bp_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  lc3b_word fetch_pc,
    input  lc3b_word fetch_instr,
    input  logic     resolve_valid,
    input  lc3b_word resolve_pc,
    input  logic     resolve_taken,
    output logic     predict_taken,
    output lc3b_word predicted_pc
);

bp_index   lookup_index;
bp_entry   lookup_entry;
bp_counter bank_counts [`BP_BANKS];

bp_update_if upd ();

assign lookup_entry = lookup_index[`BP_INDEX_BITS-`BP_BANK_SEL_BITS-1:0];

history_indexer history_indexer_module
(
    .clk(clk),
    .reset(reset),
    .fetch_pc(fetch_pc),
    .resolve_pc(resolve_pc),
    .resolve_valid(resolve_valid),
    .resolve_taken(resolve_taken),
    .lookup_index(lookup_index),
    .upd(upd.indexer)
);

// every bank reads the same entry, the generator picks one
for (genvar g = 0; g < `BP_BANKS; g++)
begin : bank_gen
    counter_bank #(.bank_id(g)) counter_bank_module
    (
        .clk(clk),
        .reset(reset),
        .read_entry(lookup_entry),
        .upd(upd.bank),
        .count(bank_counts[g])
    );
end

prediction_gen prediction_gen_module
(
    .fetch_pc(fetch_pc),
    .fetch_instr(fetch_instr),
    .lookup_index(lookup_index),
    .bank_counts(bank_counts),
    .predict_taken(predict_taken),
    .predicted_pc(predicted_pc)
);

endmodule : branch_predictor

// ==== rtl/prediction_gen.sv ====
`timescale 1ns/1ps

`include "bp_defines.svh"

module prediction_gen import lc3b_isa_pkg::*, bp_pkg::*;
(
    input  lc3b_word  fetch_pc,
    input  lc3b_word  fetch_instr,
    input  bp_index   lookup_index,
    input  bp_counter bank_counts [`BP_BANKS],
    output logic      predict_taken,
    output lc3b_word  predicted_pc
);

bp_bank_sel  bank_sel;
bp_counter   sel_count;
lc3b_opcode  opcode;
lc3b_offset9 offset9;
lc3b_word    pc_plus2;
lc3b_word    adj9;
logic        is_branch;
logic        counter_taken;

always_comb
begin
    // bank chosen by the top index bits
    bank_sel = lookup_index[`BP_INDEX_BITS-1 -: `BP_BANK_SEL_BITS];
    sel_count = bank_counts[bank_sel];

    opcode = lc3b_opcode'(fetch_instr[15:12]);
    offset9 = fetch_instr[8:0];

    // all-zero word is a NOP and never predicts
    is_branch = (opcode == op_br) && (fetch_instr != 16'h0000);
    counter_taken = (sel_count == weakly_t) || (sel_count == strongly_t);

    predict_taken = is_branch && counter_taken;
end

// target computed every cycle, whether or not a branch is predicted
always_comb
begin
    pc_plus2 = fetch_pc + 16'd2;
    adj9 = {{6{offset9[8]}}, offset9, 1'b0};    // sext, word offset to bytes
    predicted_pc = pc_plus2 + adj9;
end

endmodule : prediction_gen

// ==== rtl/counter_bank.sv ====
`timescale 1ns/1ps

`include "bp_defines.svh"

module counter_bank import bp_pkg::*;
#(
    parameter int bank_id = 0
)
(
    input  logic      clk,
    input  logic      reset,
    input  bp_entry   read_entry,
    bp_update_if.bank upd,
    output bp_counter count
);

localparam bp_bank_sel own_bank = bp_bank_sel'(bank_id);

bp_counter cnt [`BP_BANK_ENTRIES];
logic      hit;

// one saturating step toward the resolved outcome
function automatic bp_counter step(bp_counter cur, logic taken);
    bp_counter nxt;
    nxt = cur;
    unique case (cur)
        strongly_nt: nxt = taken ? weakly_nt  : strongly_nt;
        weakly_nt:   nxt = taken ? weakly_t   : strongly_nt;
        weakly_t:    nxt = taken ? strongly_t : weakly_nt;
        strongly_t:  nxt = taken ? strongly_t : weakly_t;
    endcase
    return nxt;
endfunction

assign hit = upd.update_en && (upd.update_bank == own_bank);   // update aimed here
assign count = cnt[read_entry];     // lookup sees pre-update state

always_ff @(posedge clk)
begin
    if (reset)
    begin
        for (int i = 0; i < `BP_BANK_ENTRIES; i++)
        begin
            cnt[i] <= weakly_nt;
        end
    end
    else if (hit)
    begin
        cnt[upd.update_entry] <= step(cnt[upd.update_entry], upd.taken);
    end
end

endmodule : counter_bank

// ==== rtl/history_indexer.sv ====
`timescale 1ns/1ps

`include "bp_defines.svh"

module history_indexer import lc3b_isa_pkg::*, bp_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  lc3b_word fetch_pc,
    input  lc3b_word resolve_pc,
    input  logic     resolve_valid,
    input  logic     resolve_taken,
    output bp_index  lookup_index,
    bp_update_if.indexer upd
);

localparam int hist_entries = 2 ** `BP_INDEX_BITS;

// one history per low-order fetch address
bp_history hist [hist_entries];

bp_index   fetch_slot;
bp_index   resolve_slot;
bp_history fetch_hist;
bp_history resolve_hist;
bp_index   update_index;

always_comb
begin
    fetch_slot = fetch_pc[`BP_INDEX_BITS-1:0];
    resolve_slot = resolve_pc[`BP_INDEX_BITS-1:0];

    // table reads are combinational, so both see the history before this edge
    fetch_hist = hist[fetch_slot];
    resolve_hist = hist[resolve_slot];

    lookup_index = fetch_slot ^ fetch_hist;     // gshare-style local xor
    update_index = resolve_slot ^ resolve_hist;
end

// split the update index into bank and entry for the counter banks
always_comb
begin
    upd.update_en = resolve_valid;
    upd.update_bank = update_index[`BP_INDEX_BITS-1 -: `BP_BANK_SEL_BITS];
    upd.update_entry = update_index[`BP_INDEX_BITS-`BP_BANK_SEL_BITS-1:0];
    upd.taken = resolve_taken;
end

always_ff @(posedge clk)
begin
    if (reset)
    begin
        for (int i = 0; i < hist_entries; i++)
        begin
            hist[i] <= `BP_HIST_RESET;
        end
    end
    else if (resolve_valid)
    begin
        // shift in the newest outcome
        hist[resolve_slot] <= {resolve_hist[`BP_HIST_BITS-2:0], resolve_taken};
    end
end

endmodule : history_indexer

// ==== rtl/bp_update_if.sv ====
`timescale 1ns/1ps

interface bp_update_if import bp_pkg::*; ();

    logic       update_en;      // a resolved branch trains a counter
    bp_bank_sel update_bank;    // bank holding the counter
    bp_entry    update_entry;   // counter within that bank
    logic       taken;          // resolved outcome

    modport indexer
    (
        output update_en,
        output update_bank,
        output update_entry,
        output taken
    );

    modport bank
    (
        input update_en,
        input update_bank,
        input update_entry,
        input taken
    );

endinterface : bp_update_if

// ==== rtl/bp_pkg.sv ====
`include "bp_defines.svh"

package bp_pkg;

typedef logic [`BP_INDEX_BITS-1:0] bp_index;      // table index
typedef logic [`BP_HIST_BITS-1:0] bp_history;     // local history, newest outcome in lsb

// entry within a bank and the bank number, low and high parts of an index
typedef logic [`BP_INDEX_BITS-`BP_BANK_SEL_BITS-1:0] bp_entry;
typedef logic [`BP_BANK_SEL_BITS-1:0] bp_bank_sel;

// two-bit saturating counter
// msb set means predict taken
typedef enum logic [1:0]
{
    strongly_nt = 2'b00,
    weakly_nt   = 2'b01,
    weakly_t    = 2'b10,
    strongly_t  = 2'b11
} bp_counter;

endpackage : bp_pkg

// ==== rtl/lc3b_isa_pkg.sv ====
package lc3b_isa_pkg;

typedef logic [15:0] lc3b_word;     // data word or byte address
typedef logic  [8:0] lc3b_offset9;  // BR / LD / ST pc-relative offset

// instr[15:12]
typedef enum logic [3:0]
{
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

endpackage : lc3b_isa_pkg

// ==== rtl/bp_defines.svh ====
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// history table and counter table index
`define BP_INDEX_BITS       5

// local history per entry
`define BP_HIST_BITS        5

// the counter table is split into banks
// the top index bits pick a bank, the rest pick an entry in it
`define BP_BANKS            4
`define BP_BANK_SEL_BITS    2
`define BP_BANK_ENTRIES     8

// history entries come out of reset as all zeros
`define BP_HIST_RESET       {`BP_HIST_BITS{1'b0}}

`endif
